// ==== all.f ====
+incdir+verification
hw/cpu_pkg.sv
hw/fetch_stage.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/mips_pipeline.sv
verification/tb_top.sv

// ==== hw/cpu_pkg.sv ====
/*
 * CPU package
 * Widths, instruction encodings, ALU operations and the stage register
 * layouts shared by the five-stage integer pipeline
 */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;    // data word or byte address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    // all zero is the bubble
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;   // second operand from the immediate
        alu_op_t alu_op;
        logic    is_branch;
        logic    branch_ne;     // bne when set, beq otherwise
        logic    illegal;       // undefined encoding, traps in writeback
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;         // sign extended
        reg_addr_t dst;
    } de_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dst;
    } em_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dst;
    } mw_t;

endpackage

`default_nettype wire

// ==== hw/decode_stage.sv ====
/*
 * Decode stage
 * Instruction decode, operand select with forwarding from memory,
 * early branch resolution and the decode/execute register
 */
`default_nettype none

module decode_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::word_t     fd_instr,
    input  cpu_pkg::word_t     fd_pc,
    input  cpu_pkg::word_t     rs_data,
    input  cpu_pkg::word_t     rt_data,
    input  logic               fwd_rs,
    input  logic               fwd_rt,
    input  cpu_pkg::word_t     mem_result,
    input  logic               stall,
    input  logic               freeze,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output logic               src_uses_rt,
    output cpu_pkg::de_t       de,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target
);
    import cpu_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t dst;
    ctrl_t     ctrl;
    logic      bad;
    word_t     imm;
    word_t     rs_val;
    word_t     rt_val;

    assign opcode  = fd_instr[31:26];
    assign funct   = fd_instr[5:0];
    assign rs_addr = fd_instr[25:21];
    assign rt_addr = fd_instr[20:16];
    assign imm     = {{16{fd_instr[15]}}, fd_instr[15:0]};

    always_comb
    begin
        ctrl        = '0;
        bad         = 1'b0;
        dst         = rt_addr;              // i-type writes rt
        src_uses_rt = 1'b0;
        case (opcode)
            OP_RTYPE:
            begin
                src_uses_rt    = 1'b1;
                dst            = fd_instr[15:11];
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: bad = 1'b1;
                endcase
            end
            OP_ADDI:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_LW:
            begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_SW:
            begin
                src_uses_rt      = 1'b1;    // store data
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            OP_BEQ, OP_BNE:
            begin
                src_uses_rt    = 1'b1;
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
            end
            default: bad = 1'b1;
        endcase

        if (fd_instr == '0)
            ctrl = '0;                      // all-zero word is the bubble
        else if (bad)
        begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

    assign rs_val        = fwd_rs ? mem_result : rs_data;
    assign rt_val        = fwd_rt ? mem_result : rt_data;
    assign branch_target = fd_pc + 32'd4 + {imm[29:0], 2'b00};
    assign branch_taken  = ctrl.is_branch && ((rs_val == rt_val) != ctrl.branch_ne) && !stall;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            de <= '0;
        else if (!freeze)
        begin
            if (stall)
                de <= '0;                   // bubble into execute
            else
                de <= '{ctrl: ctrl, pc: fd_pc, rs_val: rs_val, rt_val: rt_val,
                        imm: imm, dst: dst};
        end
    end

    // a stalled instruction stays in decode until its operands are ready
    a_hold_on_stall: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> fd_instr == $past(fd_instr) && fd_pc == $past(fd_pc));

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
/*
 * Execute stage
 * ALU for add, sub, and, or and signed slt, and the
 * execute/memory register
 */
`default_nettype none

module execute_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               freeze,
    input  cpu_pkg::de_t       de,
    output cpu_pkg::em_t       em,
    output cpu_pkg::ctrl_t     ex_ctrl,
    output cpu_pkg::reg_addr_t ex_dst
);
    import cpu_pkg::*;

    word_t alu_b;
    word_t alu_y;

    assign alu_b = de.ctrl.alu_src_imm ? de.imm : de.rt_val;

    always_comb
    begin
        case (de.ctrl.alu_op)
            ALU_ADD: alu_y = de.rs_val + alu_b;     // also address for lw/sw
            ALU_SUB: alu_y = de.rs_val - alu_b;
            ALU_AND: alu_y = de.rs_val & alu_b;
            ALU_OR:  alu_y = de.rs_val | alu_b;
            ALU_SLT: alu_y = {31'b0, $signed(de.rs_val) < $signed(alu_b)};
            default: alu_y = '0;
        endcase
    end

    // hazard view of the instruction now in execute
    assign ex_ctrl = de.ctrl;
    assign ex_dst  = de.dst;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            em <= '0;
        else if (!freeze)
            em <= '{ctrl: de.ctrl, pc: de.pc, alu_result: alu_y,
                    store_data: de.rt_val, dst: de.dst};
    end

endmodule

`default_nettype wire

// ==== hw/fetch_stage.sv ====
/*
 * Fetch stage
 * Program counter, instruction memory with its load port and the
 * fetch/decode register
 */
`default_nettype none

module fetch_stage #(
    parameter int IMEM_WORDS = 64
) (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           run,
    input  logic           stall,
    input  logic           freeze,
    input  logic           branch_taken,
    input  cpu_pkg::word_t branch_target,
    input  logic           prog_we,
    input  cpu_pkg::word_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    output cpu_pkg::word_t fd_instr,
    output cpu_pkg::word_t fd_pc
);
    import cpu_pkg::*;

    localparam int IAW = $clog2(IMEM_WORDS);

    word_t pc;
    word_t imem [IMEM_WORDS];

    always_ff @(posedge SYS_clk)
    begin
        if (prog_we)
            imem[prog_addr[IAW-1:0]] <= prog_data;   // word index, wraps at depth
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            pc       <= '0;
            fd_instr <= '0;
            fd_pc    <= '0;
        end
        else if (!freeze && !stall)
        begin
            if (branch_taken)
            begin
                pc       <= branch_target;
                fd_instr <= '0;             // squash the word behind the branch
            end
            else if (run)
            begin
                pc       <= pc + 32'd4;
                fd_instr <= imem[pc[IAW+1:2]];
            end
            else
                fd_instr <= '0;             // idle, bubbles only
            fd_pc <= pc;
        end
    end

    // branch targets come from decode, so alignment covers both paths
    a_pc_aligned: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hw/hazard_unit.sv ====
/*
 * Hazard unit
 * Stalls decode on a pending writer in execute or a load in memory,
 * and forwards a memory-stage ALU result into decode
 */
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  logic               src_uses_rt,
    input  cpu_pkg::ctrl_t     ex_ctrl,
    input  cpu_pkg::reg_addr_t ex_dst,
    input  cpu_pkg::ctrl_t     mem_ctrl,
    input  cpu_pkg::reg_addr_t mem_dst,
    output logic               stall,
    output logic               fwd_rs,
    output logic               fwd_rt
);
    logic ex_rs;
    logic ex_rt;
    logic mem_rs;
    logic mem_rt;
    logic stall_rs;
    logic stall_rt;

    assign ex_rs  = ex_ctrl.reg_write && ex_dst != '0 && ex_dst == rs_addr;
    assign ex_rt  = ex_ctrl.reg_write && ex_dst != '0 && ex_dst == rt_addr && src_uses_rt;
    assign mem_rs = mem_ctrl.reg_write && mem_dst != '0 && mem_dst == rs_addr;
    assign mem_rt = mem_ctrl.reg_write && mem_dst != '0 && mem_dst == rt_addr && src_uses_rt;

    assign stall_rs = ex_rs || (mem_rs && mem_ctrl.mem_read);   // load data not ready yet
    assign stall_rt = ex_rt || (mem_rt && mem_ctrl.mem_read);
    assign stall    = stall_rs || stall_rt;

    // younger writer in execute wins over memory
    assign fwd_rs = mem_rs && !mem_ctrl.mem_read && !ex_rs;
    assign fwd_rt = mem_rt && !mem_ctrl.mem_read && !ex_rt;

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
/*
 * Memory stage
 * Word-indexed data memory for lw/sw and the memory/writeback register
 */
`default_nettype none

module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               freeze,
    input  cpu_pkg::em_t       em,
    output cpu_pkg::mw_t       mw,
    output cpu_pkg::ctrl_t     mem_ctrl,
    output cpu_pkg::reg_addr_t mem_dst,
    output cpu_pkg::word_t     mem_result
);
    import cpu_pkg::*;

    localparam int DAW = $clog2(DMEM_WORDS);

    word_t          dmem [DMEM_WORDS];
    logic [DAW-1:0] word_idx;
    logic           mem_we;

    assign word_idx = em.alu_result[DAW+1:2];   // wraps at depth

    // a trapping instruction in writeback blocks the store right behind it
    assign mem_we = em.ctrl.mem_write && !freeze && !mw.ctrl.illegal;

    always_ff @(posedge SYS_clk)
    begin
        if (mem_we)
            dmem[word_idx] <= em.store_data;
    end

    assign mem_ctrl   = em.ctrl;
    assign mem_dst    = em.dst;
    assign mem_result = em.alu_result;  // forwarded into decode

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
            mw <= '0;
        else if (!freeze)
            mw <= '{ctrl: em.ctrl, pc: em.pc, alu_result: em.alu_result,
                    load_data: em.ctrl.mem_read ? dmem[word_idx] : '0, dst: em.dst};
    end

endmodule

`default_nettype wire

// ==== hw/mips_pipeline.sv ====
/*
 * MIPS-style pipeline top
 * Five in-order stages with decode-side hazard control, a program load
 * port, a register debug port and the undefined-instruction trap
 */
`default_nettype none

module mips_pipeline #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               run,
    input  logic               prog_we,
    input  cpu_pkg::word_t     prog_addr,
    input  cpu_pkg::word_t     prog_data,
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t     dbg_data,
    output logic               trap,
    output cpu_pkg::word_t     epc
);
    import cpu_pkg::*;

    word_t     fd_instr;
    word_t     fd_pc;
    word_t     branch_target;
    word_t     rs_data;
    word_t     rt_data;
    word_t     mem_result;
    word_t     wr_data;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    reg_addr_t ex_dst;
    reg_addr_t mem_dst;
    reg_addr_t wr_addr;
    logic      src_uses_rt;
    logic      branch_taken;
    logic      stall;
    logic      fwd_rs;
    logic      fwd_rt;
    logic      wr_en;
    logic      freeze;
    ctrl_t     ex_ctrl;
    ctrl_t     mem_ctrl;
    de_t       de;
    em_t       em;
    mw_t       mw;

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_fetch (
        .SYS_clk,
        .SYS_reset,
        .run,
        .stall,
        .freeze,
        .branch_taken,
        .branch_target,
        .prog_we,
        .prog_addr,
        .prog_data,
        .fd_instr,
        .fd_pc
    );

    decode_stage u_decode (
        .SYS_clk,
        .SYS_reset,
        .fd_instr,
        .fd_pc,
        .rs_data,
        .rt_data,
        .fwd_rs,
        .fwd_rt,
        .mem_result,
        .stall,
        .freeze,
        .rs_addr,
        .rt_addr,
        .src_uses_rt,
        .de,
        .branch_taken,
        .branch_target
    );

    reg_file u_regs (
        .SYS_clk,
        .SYS_reset,
        .rs_addr,
        .rt_addr,
        .wr_en,
        .wr_addr,
        .wr_data,
        .dbg_addr,
        .rs_data,
        .rt_data,
        .dbg_data
    );

    hazard_unit u_hazard (
        .rs_addr,
        .rt_addr,
        .src_uses_rt,
        .ex_ctrl,
        .ex_dst,
        .mem_ctrl,
        .mem_dst,
        .stall,
        .fwd_rs,
        .fwd_rt
    );

    execute_stage u_execute (
        .SYS_clk,
        .SYS_reset,
        .freeze,
        .de,
        .em,
        .ex_ctrl,
        .ex_dst
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .SYS_clk,
        .SYS_reset,
        .freeze,
        .em,
        .mw,
        .mem_ctrl,
        .mem_dst,
        .mem_result
    );

    writeback_stage u_writeback (
        .SYS_clk,
        .SYS_reset,
        .mw,
        .wr_en,
        .wr_addr,
        .wr_data,
        .freeze,
        .trap,
        .epc
    );

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
/*
 * Register file
 * 32 registers, two read ports and a debug port, with a same-cycle
 * write forwarded to the readers
 */
`default_nettype none

module reg_file (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data,
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    output cpu_pkg::word_t     dbg_data
);
    import cpu_pkg::*;

    word_t regs [32];

    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wr_en && wr_addr == addr)
            return wr_data;                 // write-through
        else
            return regs[addr];
    endfunction

    always_comb
    begin
        rs_data  = read_port(rs_addr);
        rt_data  = read_port(rt_addr);
        dbg_data = read_port(dbg_addr);
    end

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_addr != '0)   // r0 stays zero
            regs[wr_addr] <= wr_data;
    end

endmodule

`default_nettype wire

// ==== hw/writeback_stage.sv ====
/*
 * Writeback stage
 * Register write select and the trap/epc latch that freezes the pipeline
 */
`default_nettype none

module writeback_stage (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  cpu_pkg::mw_t       mw,
    output logic               wr_en,
    output cpu_pkg::reg_addr_t wr_addr,
    output cpu_pkg::word_t     wr_data,
    output logic               freeze,
    output logic               trap,
    output cpu_pkg::word_t     epc
);
    assign wr_data = mw.ctrl.mem_read ? mw.load_data : mw.alu_result;
    assign wr_addr = mw.dst;
    assign wr_en   = mw.ctrl.reg_write && !mw.ctrl.illegal && !trap;
    assign freeze  = trap;

    always_ff @(posedge SYS_clk or posedge SYS_reset)
    begin
        if (SYS_reset)
        begin
            trap <= 1'b0;
            epc  <= '0;
        end
        else if (mw.ctrl.illegal && !trap)
        begin
            trap <= 1'b1;                   // held until reset
            epc  <= mw.pc;
        end
    end

    // once trapped, the memory/writeback register no longer moves
    a_frozen_after_trap: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        trap |=> mw == $past(mw));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module tb_top -Mdir obj_dir -f all.f

output="$(./obj_dir/Vtb_top 2>&1 || true)"
printf '%s\n' "$output"

if grep -qx 'PASS: all tests' <<< "$output"
then
    exit 0
fi
echo "simulation did not pass"
exit 1

// ==== verification/tb_isa_model.svh ====
/*
 * Instruction-set model for the pipeline testbench
 * LCG, instruction encoders, random program generator and a
 * sequential reference model without delay slots
 */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam int    KIND_MIX    = 0;
localparam int    KIND_INDEP  = 1;
localparam int    KIND_CHAIN  = 2;
localparam int    KIND_MEM    = 3;
localparam int    KIND_BRANCH = 4;
localparam int    KIND_CLEAR  = 5;
localparam int    DATA_WORDS  = 16;             // words reachable by lw/sw offsets
localparam int    IAW         = $clog2(IMEM_WORDS);
localparam int    DAW         = $clog2(DMEM_WORDS);
localparam word_t TRAP_WORD   = 32'hfc00_0000;  // opcode 6'h3f is undefined

logic [31:0] lcg_state;
word_t       prog [IMEM_WORDS];
int          prog_len;
word_t       model_regs [32];
word_t       model_dmem [DMEM_WORDS];
word_t       model_trap_pc;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);     // low bits of an LCG repeat quickly
endfunction

function automatic word_t r_type_word(input reg_addr_t rd, input reg_addr_t rs,
                                      input reg_addr_t rt, input funct_t fn);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic word_t i_type_word(input opcode_t op, input reg_addr_t rs,
                                      input reg_addr_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic void append_word(input word_t w);
    if (prog_len < IMEM_WORDS)
    begin
        prog[prog_len] = w;
        prog_len++;
    end
endfunction

function automatic void gen_program(input int kind);
    int          n;
    int          op;
    int          pool;
    int          span;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    reg_addr_t   rd2;
    reg_addr_t   last1;
    reg_addr_t   last2;
    logic [15:0] imm;
    logic [15:0] off;

    prog_len = 0;
    last1    = '0;
    last2    = '0;
    if (kind == KIND_CLEAR)
    begin
        for (int k = 0; k < DATA_WORDS; k++)
            append_word(i_type_word(OP_SW, 5'd0, 5'd0, 16'(k * 4)));
        append_word(TRAP_WORD);
        return;
    end

    case (kind)
        KIND_INDEP:  pool = 32;
        KIND_CHAIN:  pool = 5;                  // few registers, many hazards
        KIND_BRANCH: pool = 4;                  // equal operands are common
        default:     pool = 8;
    endcase
    n = 8 + rand_below(MAX_BODY - 7);

    while (prog_len < n)
    begin
        rs  = reg_addr_t'(rand_below(pool));
        rt  = reg_addr_t'(rand_below(pool));
        rd  = reg_addr_t'(1 + rand_below(pool - 1));
        rd2 = reg_addr_t'(1 + rand_below(pool - 1));
        imm = 16'(rand_below(65536));
        off = 16'(rand_below(DATA_WORDS) * 4);
        case (kind)
            KIND_INDEP:
            begin
                op = rand_below(6);
                if (rs == last1 || rs == last2)
                    rs = '0;                    // keep neighbours independent
                if (rt == last1 || rt == last2)
                    rt = '0;
            end
            KIND_CHAIN:
            begin
                op = rand_below(6);
                rs = last1;                     // consume the previous result
            end
            KIND_MEM:    op = (rand_below(3) == 0) ? 5 : 10 + rand_below(2);
            KIND_BRANCH: op = (rand_below(3) == 0) ? 8 + rand_below(2) : rand_below(6);
            default:     op = rand_below(10);
        endcase
        last2 = last1;
        last1 = rd;
        case (op)
            0: append_word(r_type_word(rd, rs, rt, FN_ADD));
            1: append_word(r_type_word(rd, rs, rt, FN_SUB));
            2: append_word(r_type_word(rd, rs, rt, FN_AND));
            3: append_word(r_type_word(rd, rs, rt, FN_OR));
            4: append_word(r_type_word(rd, rs, rt, FN_SLT));
            5: append_word(i_type_word(OP_ADDI, rs, rd, imm));
            6: append_word(i_type_word(OP_LW, 5'd0, rd, off));
            7:
            begin
                append_word(i_type_word(OP_SW, 5'd0, rt, off));
                last1 = '0;
            end
            8, 9:
            begin
                span = n - prog_len;            // target stays at or before the trap word
                if (span > 4)
                    span = 4;
                append_word(i_type_word(op == 8 ? OP_BEQ : OP_BNE, rs, rt,
                                        16'(rand_below(span))));
                last1 = '0;
            end
            10:
            begin
                append_word(i_type_word(OP_SW, 5'd0, rt, off));
                append_word(i_type_word(OP_LW, 5'd0, rd, off));
            end
            default:
            begin
                append_word(i_type_word(OP_LW, 5'd0, rd, off));
                append_word(r_type_word(rd2, rd, rt, FN_ADD));  // load-use
                last1 = rd2;
            end
        endcase
    end
    append_word(TRAP_WORD);
endfunction

function automatic void run_model();
    word_t          pc;
    word_t          this_pc;
    word_t          instr;
    word_t          a;
    word_t          b;
    word_t          imm;
    word_t          res;
    word_t          addr;
    reg_addr_t      dst;
    logic [IAW-1:0] iidx;
    logic [DAW-1:0] didx;
    logic           writes;
    logic           illegal;
    logic           done;
    int             steps;

    for (int r = 0; r < 32; r++)
        model_regs[r] = '0;
    pc            = '0;
    done          = 1'b0;
    steps         = 0;
    model_trap_pc = '1;                         // stays if no trap is reached
    while (!done && steps < 4 * IMEM_WORDS)
    begin
        iidx    = pc[IAW+1:2];
        instr   = prog[iidx];
        this_pc = pc;
        pc      = pc + 32'd4;
        a       = model_regs[instr[25:21]];
        b       = model_regs[instr[20:16]];
        imm     = {{16{instr[15]}}, instr[15:0]};
        addr    = a + imm;
        didx    = addr[DAW+1:2];
        dst     = instr[20:16];
        res     = '0;
        writes  = 1'b1;
        illegal = 1'b0;
        case (instr[31:26])
            OP_RTYPE:
            begin
                dst = instr[15:11];
                case (instr[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: illegal = 1'b1;
                endcase
            end
            OP_ADDI: res = addr;
            OP_LW:   res = model_dmem[didx];
            OP_SW:
            begin
                model_dmem[didx] = b;
                writes           = 1'b0;
            end
            OP_BEQ, OP_BNE:
            begin
                writes = 1'b0;
                if ((a == b) == (instr[31:26] == OP_BEQ))
                    pc = pc + (imm << 2);
            end
            default: illegal = 1'b1;
        endcase
        if (illegal)
        begin
            model_trap_pc = this_pc;
            done          = 1'b1;
        end
        else if (writes && dst != '0)
            model_regs[dst] = res;
        steps++;
    end
endfunction

`endif

// ==== verification/tb_top.sv ====
/*
 * Testbench for the five-stage pipeline
 * Loads random programs, runs each to its trap and compares the
 * register file and epc with the sequential model
 */
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int IMEM_WORDS     = 64;
    localparam int DMEM_WORDS     = 64;
    localparam int MAX_BODY       = 39;
    localparam int MAX_PROG_WORDS = MAX_BODY + 2;   // final pair and the trap word
    localparam int PROGS_PER_KIND = 3;
    localparam int NUM_RANDOM     = 30;
    localparam int NUM_PROGRAMS   = 1 + 4 * PROGS_PER_KIND + NUM_RANDOM;
    localparam int CLK_PERIOD     = 10;
    localparam int WATCHDOG_NS    = 200 * MAX_PROG_WORDS * NUM_PROGRAMS * CLK_PERIOD;

    logic      SYS_clk;
    logic      SYS_reset;
    logic      run;
    logic      prog_we;
    word_t     prog_addr;
    word_t     prog_data;
    reg_addr_t dbg_addr;
    word_t     dbg_data;
    logic      trap;
    word_t     epc;
    int        error_count;

    `include "tb_isa_model.svh"

    mips_pipeline #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) DUT (
        .SYS_clk,
        .SYS_reset,
        .run,
        .prog_we,
        .prog_addr,
        .prog_data,
        .dbg_addr,
        .dbg_data,
        .trap,
        .epc
    );

    initial
    begin
        SYS_clk = 1'b0;
        forever #(CLK_PERIOD / 2) SYS_clk = ~SYS_clk;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic apply_reset();
        @(negedge SYS_clk);
        run       = 1'b0;
        SYS_reset = 1'b1;
        repeat (5) @(negedge SYS_clk);
        SYS_reset = 1'b0;
        check_value("trap", 32'd0, {31'b0, trap});  // clean start after reset
        check_value("epc", 32'd0, epc);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++)
        begin
            @(negedge SYS_clk);
            prog_we   = 1'b1;
            prog_addr = 32'(i);                     // word index
            prog_data = prog[i];
        end
        @(negedge SYS_clk);
        prog_we = 1'b0;
    endtask

    task automatic compare_regs();
        for (int r = 0; r < 32; r++)
        begin
            @(negedge SYS_clk);
            dbg_addr = reg_addr_t'(r);
            #1;
            check_value($sformatf("r%0d", r), model_regs[r], dbg_data);
        end
    endtask

    task automatic run_program(input int kind);
        gen_program(kind);
        run_model();
        apply_reset();
        load_program();
        @(negedge SYS_clk);
        run = 1'b1;
        while (!trap)
            @(negedge SYS_clk);                     // watchdog bounds this wait
        check_value("epc", model_trap_pc, epc);
        repeat (4) @(negedge SYS_clk);
        check_value("trap", 32'd1, {31'b0, trap});  // held until reset
        check_value("epc", model_trap_pc, epc);
        compare_regs();
        @(negedge SYS_clk);
        run = 1'b0;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, trap never rose", $time);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        SYS_reset   = 1'b1;
        run         = 1'b0;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        dbg_addr    = '0;
        error_count = 0;
        lcg_state   = 32'hbe49;
        for (int i = 0; i < DMEM_WORDS; i++)
            model_dmem[i] = '0;

        run_program(KIND_CLEAR);                    // known data memory for loads
        for (int k = KIND_INDEP; k <= KIND_BRANCH; k++)
            repeat (PROGS_PER_KIND) run_program(k);
        repeat (NUM_RANDOM) run_program(KIND_MIX);

        if (error_count == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire
